// File: alu.f
+incdir+sim
common/alu_pkg.sv
alu_datapath/fx_arith_unit.sv
alu_datapath/alu_datapath.sv
rtl/alu_control.sv
rtl/alu_top.sv
sim/tb_alu.sv

// File: alu_datapath/alu_datapath.sv
`default_nettype none

module alu_datapath import alu_pkg::*; (
    input  wire      i_clk,
    input  wire      i_reset_n,
    input  data_t    i_data_a,
    input  data_t    i_data_b,
    input  fx_op_e   i_fx_op,
    input  src_sel_e i_src_a,
    input  src_sel_e i_src_b,
    input  wire      i_save_result,
    input  wire      i_save_saved,
    input  wire      i_load_rot,
    input  wire      i_load_lfsr,
    input  wire      i_rotate,
    input  wire      i_lfsr_step,
    input  wire      i_clr_count,
    input  wire      i_step_count,
    input  wire      i_step_popcount,
    output data_t    o_data,
    output logic     o_clz_more,
    output logic     o_pop_more,
    output logic     o_rot_more,
    output logic     o_lfsr_more
);

    localparam int IDX_W = $clog2(DATA_W);

    data_t  saved;
    data_t  rot_reg;     // GPR 0 in LRCW
    data_t  lfsr_reg;    // GPR 1 in LFSR
    count_t count;
    count_t pop_count;
    data_t  op_a, op_b;
    data_t  fx_result;
    logic [IDX_W-1:0] clz_idx;

    function automatic data_t pick_src(input src_sel_e sel);
        case (sel)
            SRC_DATA_A:   return i_data_a;
            SRC_DATA_B:   return i_data_b;
            SRC_SAVED:    return saved;
            SRC_RESULT:   return o_data;
            SRC_ROT_REG:  return rot_reg;
            SRC_LFSR_REG: return lfsr_reg;
            SRC_COUNT:    return data_t'(count);
            default:      return i_data_a;
        endcase
    endfunction

    always_comb begin
        op_a = pick_src(i_src_a);
        op_b = pick_src(i_src_b);
    end

    fx_arith_unit u_arith (
        .i_op     (i_fx_op),
        .i_a      (op_a),
        .i_b      (op_b),
        .o_result (fx_result)
    );

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_data    <= '0;    // first MAC accumulates onto zero
            count     <= '0;
            pop_count <= '0;
        end else begin
            if (i_save_result) o_data <= fx_result;
            if (i_clr_count) begin
                count <= '0;
            end else if (i_step_count) begin
                count <= count + 1'b1;
            end
            if (i_load_rot) begin
                pop_count <= '0;    // new LRCW
            end else if (i_step_popcount && saved[count[IDX_W-1:0]]) begin
                pop_count <= pop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_save_saved) saved <= fx_result;
        if (i_load_rot) begin
            rot_reg <= fx_result;
        end else if (i_rotate) begin
            rot_reg <= {rot_reg[DATA_W-2:0], ~rot_reg[DATA_W-1]};
        end
        if (i_load_lfsr) begin
            lfsr_reg <= fx_result;
        end else if (i_lfsr_step) begin
            // taps 16,14,13,11
            lfsr_reg <= {lfsr_reg[DATA_W-2:0],
                         lfsr_reg[15] ^ lfsr_reg[13] ^ lfsr_reg[12] ^ lfsr_reg[10]};
        end
    end

    assign clz_idx     = IDX_W'(DATA_W - 1) - count[IDX_W-1:0];    // msb first
    assign o_pop_more  = count < count_t'(DATA_W);
    assign o_clz_more  = o_pop_more && !saved[clz_idx];
    assign o_rot_more  = count < pop_count;
    assign o_lfsr_more = count < count_t'(saved);

endmodule

`default_nettype wire

// File: alu_datapath/fx_arith_unit.sv
`default_nettype none

module fx_arith_unit import alu_pkg::*; (
    input  fx_op_e i_op,
    input  data_t  i_a,
    input  data_t  i_b,
    output data_t  o_result
);

    localparam data_t SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam data_t SAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};
    localparam int    INT_MAX = 2**(INT_W-1) - 1;    // 31
    localparam int    INT_MIN = -(2**(INT_W-1));     // -32

    logic signed [2*DATA_W-1:0]          product;
    logic signed [2*(DATA_W-FRAC_W)-1:0] prod_int;    // integer part of Q12.20
    data_t                               prod_mid;
    data_t                               sum, diff;
    logic                                add_ovf, sub_ovf;

    assign product  = i_a * i_b;
    assign prod_int = product[2*DATA_W-1:2*FRAC_W];
    assign prod_mid = product[DATA_W+FRAC_W-1:FRAC_W];    // back to Q6.10

    assign sum  = i_a + i_b;
    assign diff = i_a - i_b;

    // same signs in, other sign out
    assign add_ovf = (i_a[DATA_W-1] == i_b[DATA_W-1]) && (sum[DATA_W-1] != i_a[DATA_W-1]);
    assign sub_ovf = (i_a[DATA_W-1] != i_b[DATA_W-1]) && (diff[DATA_W-1] != i_a[DATA_W-1]);

    always_comb begin
        o_result = '0;
        case (i_op)
            FX_ADD: begin
                if (add_ovf) begin
                    o_result = i_a[DATA_W-1] ? SAT_MIN : SAT_MAX;
                end else begin
                    o_result = sum;
                end
            end
            FX_SUB: begin
                if (sub_ovf) begin
                    o_result = i_a[DATA_W-1] ? SAT_MIN : SAT_MAX;
                end else begin
                    o_result = diff;
                end
            end
            FX_MULT: begin
                if (prod_int > INT_MAX) begin
                    o_result = SAT_MAX;
                end else if (prod_int < INT_MIN) begin
                    o_result = SAT_MIN;
                end else if (product[FRAC_W-1] && prod_mid != SAT_MAX) begin
                    o_result = prod_mid + data_t'(1);    // round half up
                end else begin
                    o_result = prod_mid;
                end
            end
            FX_PASS_A: o_result = i_a;
            FX_ZERO:   o_result = '0;
            default:   o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: common/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // Q6.10 word
    localparam int INT_W  = 6;
    localparam int FRAC_W = 10;
    localparam int DATA_W = INT_W + FRAC_W;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic        [DATA_W-1:0] count_t;    // loop counters

    // instruction codes, 4 and 8..15 have no operation
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_MULT = 4'd2,
        OP_MAC  = 4'd3,
        OP_CLZ  = 4'd5,
        OP_LRCW = 4'd6,
        OP_LFSR = 4'd7
    } alu_op_e;

    typedef enum logic [2:0] {FX_ADD, FX_SUB, FX_MULT, FX_PASS_A, FX_ZERO} fx_op_e;

    typedef enum logic [2:0] {
        SRC_DATA_A, SRC_DATA_B, SRC_SAVED, SRC_RESULT, SRC_ROT_REG, SRC_LFSR_REG, SRC_COUNT
    } src_sel_e;

    typedef enum logic [3:0] {
        START, READY, WAIT, CALCULATE, MAC_ADD, CLZ_SCAN, LOAD_ROT,
        POPCOUNT, ROTATE, LOAD_LFSR, LFSR_SHIFT, FINISH
    } alu_state_e;

endpackage

`default_nettype wire

// File: rtl/alu_control.sv
`default_nettype none

module alu_control import alu_pkg::*; (
    input  wire      i_clk,
    input  wire      i_reset_n,
    input  alu_op_e  i_inst,
    input  wire      i_clz_more,
    input  wire      i_pop_more,
    input  wire      i_rot_more,
    input  wire      i_lfsr_more,
    output logic     o_busy,
    output logic     o_valid,
    output fx_op_e   o_fx_op,
    output src_sel_e o_src_a,
    output src_sel_e o_src_b,
    output logic     o_save_result,
    output logic     o_save_saved,
    output logic     o_load_rot,
    output logic     o_load_lfsr,
    output logic     o_rotate,
    output logic     o_lfsr_step,
    output logic     o_clr_count,
    output logic     o_step_count,
    output logic     o_step_popcount
);

    alu_state_e state, state_nxt;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state <= START;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt       = state;
        o_busy          = 1'b1;
        o_valid         = 1'b0;
        o_fx_op         = FX_PASS_A;
        o_src_a         = SRC_DATA_A;
        o_src_b         = SRC_DATA_B;
        o_save_result   = 1'b0;
        o_save_saved    = 1'b0;
        o_load_rot      = 1'b0;
        o_load_lfsr     = 1'b0;
        o_rotate        = 1'b0;
        o_lfsr_step     = 1'b0;
        o_clr_count     = 1'b0;
        o_step_count    = 1'b0;
        o_step_popcount = 1'b0;

        case (state)
            START: state_nxt = READY;
            READY: begin
                o_busy    = 1'b0;    // one cycle window for a new op
                state_nxt = WAIT;
            end
            WAIT:  state_nxt = CALCULATE;    // operands settle
            CALCULATE: begin
                state_nxt = FINISH;
                case (i_inst)
                    OP_ADD:  begin o_fx_op = FX_ADD;  o_save_result = 1'b1; end
                    OP_SUB:  begin o_fx_op = FX_SUB;  o_save_result = 1'b1; end
                    OP_MULT: begin o_fx_op = FX_MULT; o_save_result = 1'b1; end
                    OP_MAC: begin
                        o_fx_op      = FX_MULT;    // keep product, add next cycle
                        o_save_saved = 1'b1;
                        state_nxt    = MAC_ADD;
                    end
                    OP_CLZ: begin
                        o_save_saved = 1'b1;    // a to saved for the scan
                        o_clr_count  = 1'b1;
                        state_nxt    = CLZ_SCAN;
                    end
                    OP_LRCW: begin
                        o_save_saved = 1'b1;    // a is the popcount source
                        o_clr_count  = 1'b1;
                        state_nxt    = LOAD_ROT;
                    end
                    OP_LFSR: begin
                        o_src_a      = SRC_DATA_B;    // b is the step count
                        o_save_saved = 1'b1;
                        o_clr_count  = 1'b1;
                        state_nxt    = LOAD_LFSR;
                    end
                    default: begin
                        o_fx_op       = FX_ZERO;
                        o_save_result = 1'b1;
                    end
                endcase
            end
            MAC_ADD: begin
                o_fx_op       = FX_ADD;
                o_src_a       = SRC_SAVED;
                o_src_b       = SRC_RESULT;    // previous o_data
                o_save_result = 1'b1;
                state_nxt     = FINISH;
            end
            CLZ_SCAN: begin
                if (i_clz_more) begin
                    o_step_count = 1'b1;
                end else begin
                    o_src_a       = SRC_COUNT;
                    o_save_result = 1'b1;
                    state_nxt     = FINISH;
                end
            end
            LOAD_ROT: begin
                o_src_a    = SRC_DATA_B;
                o_load_rot = 1'b1;    // also clears the popcount
                state_nxt  = POPCOUNT;
            end
            POPCOUNT: begin
                if (i_pop_more) begin
                    o_step_count    = 1'b1;
                    o_step_popcount = 1'b1;
                end else begin
                    o_clr_count = 1'b1;    // reuse step counter for rotates
                    state_nxt   = ROTATE;
                end
            end
            ROTATE: begin
                if (i_rot_more) begin
                    o_rotate     = 1'b1;
                    o_step_count = 1'b1;
                end else begin
                    o_src_a       = SRC_ROT_REG;
                    o_save_result = 1'b1;
                    state_nxt     = FINISH;
                end
            end
            LOAD_LFSR: begin
                o_load_lfsr = 1'b1;    // seed from a
                state_nxt   = LFSR_SHIFT;
            end
            LFSR_SHIFT: begin
                if (i_lfsr_more) begin
                    o_lfsr_step  = 1'b1;
                    o_step_count = 1'b1;
                end else begin
                    o_src_a       = SRC_LFSR_REG;
                    o_save_result = 1'b1;
                    state_nxt     = FINISH;
                end
            end
            FINISH: begin
                o_valid   = 1'b1;
                state_nxt = READY;
            end
            default: state_nxt = START;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/alu_top.sv
`default_nettype none

module alu_top import alu_pkg::*; (
    input  wire     i_clk,
    input  wire     i_reset_n,
    input  alu_op_e i_inst,
    input  data_t   i_data_a,
    input  data_t   i_data_b,
    output logic    o_valid,
    output logic    o_busy,
    output data_t   o_data
);

    // control to datapath strobes
    fx_op_e   fx_op;
    src_sel_e src_a;
    src_sel_e src_b;
    logic     save_result;
    logic     save_saved;
    logic     load_rot;
    logic     load_lfsr;
    logic     rotate;
    logic     lfsr_step;
    logic     clr_count;
    logic     step_count;
    logic     step_popcount;

    // loop status back to control
    logic     clz_more;
    logic     pop_more;
    logic     rot_more;
    logic     lfsr_more;

    alu_control u_control (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_inst          (i_inst),
        .i_clz_more      (clz_more),
        .i_pop_more      (pop_more),
        .i_rot_more      (rot_more),
        .i_lfsr_more     (lfsr_more),
        .o_busy          (o_busy),
        .o_valid         (o_valid),
        .o_fx_op         (fx_op),
        .o_src_a         (src_a),
        .o_src_b         (src_b),
        .o_save_result   (save_result),
        .o_save_saved    (save_saved),
        .o_load_rot      (load_rot),
        .o_load_lfsr     (load_lfsr),
        .o_rotate        (rotate),
        .o_lfsr_step     (lfsr_step),
        .o_clr_count     (clr_count),
        .o_step_count    (step_count),
        .o_step_popcount (step_popcount)
    );

    alu_datapath u_datapath (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_data_a        (i_data_a),
        .i_data_b        (i_data_b),
        .i_fx_op         (fx_op),
        .i_src_a         (src_a),
        .i_src_b         (src_b),
        .i_save_result   (save_result),
        .i_save_saved    (save_saved),
        .i_load_rot      (load_rot),
        .i_load_lfsr     (load_lfsr),
        .i_rotate        (rotate),
        .i_lfsr_step     (lfsr_step),
        .i_clr_count     (clr_count),
        .i_step_count    (step_count),
        .i_step_popcount (step_popcount),
        .o_data          (o_data),
        .o_clz_more      (clz_more),
        .o_pop_more      (pop_more),
        .o_rot_more      (rot_more),
        .o_lfsr_more     (lfsr_more)
    );

endmodule

`default_nettype wire

// File: sim/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// expected results from the Q6.10 rules, included inside tb_alu

function automatic data_t clamp_word(input int value);
    if (value > 32767) return 16'sh7FFF;
    if (value < -32768) return 16'sh8000;
    return data_t'(value);
endfunction

function automatic data_t sat_add(input data_t a, input data_t b);
    return clamp_word(int'(a) + int'(b));
endfunction

function automatic data_t sat_sub(input data_t a, input data_t b);
    return clamp_word(int'(a) - int'(b));
endfunction

function automatic data_t round_mult(input data_t a, input data_t b);
    int    prod;     // Q12.20
    int    whole;
    data_t mid;
    prod  = int'(a) * int'(b);
    whole = prod >>> 20;
    if (whole > 31) return 16'sh7FFF;
    if (whole < -32) return 16'sh8000;
    mid = data_t'(prod >>> 10);
    if (prod[9] && mid != 16'sh7FFF) mid = mid + 16'sd1;    // half rounds up
    return mid;
endfunction

function automatic int lead_zeros(input data_t a);
    int n;
    n = 0;
    for (int i = 15; i >= 0; i--) begin
        if (a[i]) break;
        n++;
    end
    return n;
endfunction

// b rotated left popcount(a) times, inverted msb enters at bit 0
function automatic data_t comp_rotate(input data_t a, input data_t b);
    data_t r;
    r = b;
    repeat ($countones(a)) r = {r[14:0], ~r[15]};
    return r;
endfunction

function automatic data_t lfsr_advance(input data_t start, input int steps);
    data_t r;
    r = start;
    repeat (steps) r = {r[14:0], r[15] ^ r[13] ^ r[12] ^ r[10]};
    return r;
endfunction

`endif

// File: sim/tb_alu.sv
`default_nettype none

module tb_alu import alu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 20000;    // about 150 ops of up to 80 cycles

    logic    clk;
    logic    reset_n;
    alu_op_e inst;
    data_t   data_a;
    data_t   data_b;
    logic    valid;
    logic    busy;
    data_t   data_out;

    integer  seed;
    int      cycle_count = 0;
    int      op_cycles;     // busy-low cycle to o_valid
    data_t   last_data;     // o_data of the previous op, MAC input

    `include "alu_model.svh"

    alu_top UUT (
        .i_clk     (clk),
        .i_reset_n (reset_n),
        .i_inst    (inst),
        .i_data_a  (data_a),
        .i_data_b  (data_b),
        .o_valid   (valid),
        .o_busy    (busy),
        .o_data    (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the DUT did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "run stopped at the cycle limit");
        end
    end

    task automatic compare_value(input string name, input logic signed [31:0] expected,
                                 input logic signed [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0d (0x%h), actual %0d (0x%h)",
                     name, expected, expected, actual, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        compare_value("reset busy", 1, busy);
        compare_value("reset valid", 0, valid);
        compare_value("reset data", 0, data_out);
        reset_n   = 1'b1;
        last_data = '0;
    endtask

    // one op, inputs presented in the busy-low cycle and held until o_valid
    task automatic do_op(input string name, input alu_op_e op, input data_t a,
                         input data_t b, input data_t expected);
        while (busy) begin
            @(posedge clk);
            #2;
        end
        inst      = op;
        data_a    = a;
        data_b    = b;
        op_cycles = 0;
        do begin
            @(posedge clk);
            #2;
            op_cycles++;
            compare_value({name, " busy"}, 1, busy);
        end while (!valid);
        compare_value(name, expected, data_out);
        @(posedge clk);
        #2;
        compare_value({name, " valid width"}, 0, valid);    // strobe lasts one cycle
        compare_value({name, " ready after valid"}, 0, busy);
        compare_value({name, " data held"}, expected, data_out);
        last_data = expected;
    endtask

    task automatic timing_cases();
        int    zero_codes [9] = '{4, 8, 9, 10, 11, 12, 13, 14, 15};
        data_t a;
        data_t b;
        do_op("add latency op", OP_ADD, 16'sh0400, 16'sh0C00, 16'sh1000);
        compare_value("add latency", 3, op_cycles);
        a = 16'sh0800;
        b = 16'sh0600;
        do_op("mac latency op", OP_MAC, a, b, sat_add(round_mult(a, b), last_data));
        compare_value("mac latency", 4, op_cycles);
        foreach (zero_codes[i]) begin
            do_op("add before zero op", OP_ADD, 16'sh0400, 16'sh0400, 16'sh0800);
            a = data_t'($random(seed));
            b = data_t'($random(seed));
            do_op("zero opcode", alu_op_e'(zero_codes[i]), a, b, 16'sh0000);
        end
    endtask

    task automatic add_sub_cases();
        data_t edge_a [6] = '{16'sh7FFF, 16'sh8000, 16'sh7FFF, 16'sh4000, 16'sh8000, 16'sh7FFF};
        data_t edge_b [6] = '{16'sh0001, 16'shFFFF, 16'sh8000, 16'sh4000, 16'sh0001, 16'shFFFF};
        data_t a;
        data_t b;
        foreach (edge_a[i]) begin
            do_op("add edge", OP_ADD, edge_a[i], edge_b[i], sat_add(edge_a[i], edge_b[i]));
            do_op("sub edge", OP_SUB, edge_a[i], edge_b[i], sat_sub(edge_a[i], edge_b[i]));
        end
        repeat (15) begin
            a = data_t'($random(seed));
            b = data_t'($random(seed));
            do_op("add random", OP_ADD, a, b, sat_add(a, b));
            do_op("sub random", OP_SUB, a, b, sat_sub(a, b));
        end
    endtask

    task automatic mult_cases();
        // overflow, underflow, exact -32, round carry, max without round
        data_t edge_a [8] = '{16'sh7FFF, 16'sh4000, 16'sh8000, 16'sh8000,
                              16'sh0001, 16'sh48C7, 16'sh8000, 16'shFC00};
        data_t edge_b [8] = '{16'sh7FFF, 16'sh0800, 16'sh0800, 16'sh0400,
                              16'sh0200, 16'sh0709, 16'sh8000, 16'sh0001};
        data_t a;
        data_t b;
        foreach (edge_a[i]) begin
            do_op("mult edge", OP_MULT, edge_a[i], edge_b[i], round_mult(edge_a[i], edge_b[i]));
        end
        repeat (15) begin
            a = data_t'($random(seed));
            b = data_t'($random(seed));
            do_op("mult random", OP_MULT, a, b, round_mult(a, b));
        end
    endtask

    task automatic mac_chain();
        data_t chain_a [11];
        data_t chain_b [11];
        apply_reset();    // chain starts from o_data = 0
        for (int i = 0; i < 6; i++) begin
            chain_a[i] = data_t'($random(seed));
            chain_b[i] = data_t'($random(seed));
        end
        chain_a[6]  = 16'sh7FFF;
        chain_b[6]  = 16'sh7FFF;
        chain_a[7]  = 16'sh7FFF;
        chain_b[7]  = 16'sh7FFF;
        for (int i = 8; i < 11; i++) begin
            chain_a[i] = 16'sh8000;    // walks down into the low limit
            chain_b[i] = 16'sh7FFF;
        end
        foreach (chain_a[i]) begin
            do_op("mac chain", OP_MAC, chain_a[i], chain_b[i],
                  sat_add(round_mult(chain_a[i], chain_b[i]), last_data));
        end
    endtask

    task automatic clz_cases();
        data_t a;
        do_op("clz zero", OP_CLZ, 16'sh0000, 16'sh0000, 16'sd16);
        for (int i = 0; i < 16; i++) begin
            a = data_t'(1) << i;
            do_op("clz one-hot", OP_CLZ, a, 16'sh0000, data_t'(lead_zeros(a)));
        end
        for (int i = 0; i < 16; i++) begin
            a = data_t'($random(seed));
            a = a >> i;
            do_op("clz random", OP_CLZ, a, 16'sh0000, data_t'(lead_zeros(a)));
        end
    endtask

    task automatic lrcw_lfsr_cases();
        data_t a;
        data_t b;
        b = 16'sh1234;
        do_op("lrcw no bits", OP_LRCW, 16'sh0000, b, comp_rotate(16'sh0000, b));
        do_op("lrcw all bits", OP_LRCW, 16'shFFFF, b, comp_rotate(16'shFFFF, b));
        repeat (10) begin
            a = data_t'($random(seed));
            b = data_t'($random(seed));
            do_op("lrcw random", OP_LRCW, a, b, comp_rotate(a, b));
        end
        a = 16'shACE1;
        do_op("lfsr zero steps", OP_LFSR, a, 16'sh0000, a);
        do_op("lfsr max steps", OP_LFSR, a, 16'sd63, lfsr_advance(a, 63));
        repeat (10) begin
            a = data_t'($random(seed));
            b = data_t'($random(seed)) & 16'sh003F;
            do_op("lfsr random", OP_LFSR, a, b, lfsr_advance(a, int'(b)));
        end
    endtask

    initial begin
        seed      = 87934;
        reset_n   = 1'b0;
        inst      = OP_ADD;
        data_a    = '0;
        data_b    = '0;
        last_data = '0;
        apply_reset();
        timing_cases();
        add_sub_cases();
        mult_cases();
        mac_chain();
        clz_cases();
        lrcw_lfsr_cases();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
